// ==== hdl/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Bus widths
`define DC_ADDR_W      32
`define DC_WORD_W      32
`define DC_STRB_W      4

// Direct mapped cache geometry
`define DC_TAG_W       19
`define DC_INDEX_W     7
`define DC_OFFSET_W    4
`define DC_LINE_WORDS  16
`define DC_LINES       128

`endif

// ==== hdl/dcache_pkg.sv ====
`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

    typedef struct packed {
        logic [`DC_TAG_W-1:0]    tag;
        logic [`DC_INDEX_W-1:0]  index;
        logic [`DC_OFFSET_W-1:0] offset;
        logic [1:0]              byte_sel;
    } addr_fields_t;

    // Tag in the low bits
    typedef struct packed {
        logic [`DC_LINE_WORDS-1:0][`DC_WORD_W-1:0] words;
        logic [`DC_TAG_W-1:0]                      tag;
    } line_t;

    typedef struct packed {
        logic                  en;
        logic [`DC_STRB_W-1:0] wstrb;      // Zero for a read
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_WORD_W-1:0] wdata;
        logic                  uncached;
    } cpu_req_t;

    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;
        logic                  valid;
        logic                  uncached;
    } rd_req_t;

    typedef struct packed {
        logic [`DC_WORD_W-1:0] data;
        logic                  valid;
        logic                  last;
    } rd_rsp_t;

    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;
        logic                  valid;
        logic                  uncached;
        logic [`DC_STRB_W-1:0] strb;
    } wr_req_t;

    typedef struct packed {
        logic [`DC_WORD_W-1:0] data;
        logic                  valid;
        logic                  last;
        logic [`DC_STRB_W-1:0] strb;
    } wr_beat_t;

    typedef struct packed {
        logic addr_ok;
        logic wready;
        logic bvalid;
    } wr_rsp_t;

    typedef struct packed {
        logic                  start;
        logic                  line;       // 1 for a 16 beat writeback
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_WORD_W-1:0] word;
        logic [`DC_STRB_W-1:0] strb;
    } wb_cmd_t;

    typedef enum logic [2:0] {
        IDLE,
        CACHED_RSHAKE,
        CACHED_RWAIT,
        CACHED_WWAIT,
        CACHED_REFILL,
        UNCACHED_RSHAKE,
        UNCACHED_RETURN,
        UNCACHED_WWAIT
    } ctrl_state_t;

    typedef enum logic [1:0] {
        WIDLE,
        WSHAKE,
        WWRITE,
        WRESULT
    } wr_state_t;

endpackage

`default_nettype wire

// ==== hdl/dcache_line_store.sv ====
`default_nettype none

`include "dcache_consts.svh"

module dcache_line_store (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [`DC_INDEX_W-1:0] index,
    input  wire logic                   we,
    input  dcache_pkg::line_t           wline,
    input  wire logic                   set_dirty,
    input  wire logic                   clear_dirty,
    output dcache_pkg::line_t           rline,
    output logic                        valid,
    output logic                        dirty
);

    dcache_pkg::line_t      lines [`DC_LINES];
    logic [`DC_LINES-1:0]   valid_bits;
    logic [`DC_LINES-1:0]   dirty_bits;

    always_ff @(posedge clk) begin
        if (we) begin
            lines[index] <= wline;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (we) begin
            valid_bits[index] <= 1'b1;
        end
    end

    // Refill wins over a write hit
    always_ff @(posedge clk) begin
        if (rst) begin
            dirty_bits <= '0;
        end else if (clear_dirty) begin
            dirty_bits[index] <= 1'b0;
        end else if (set_dirty) begin
            dirty_bits[index] <= 1'b1;
        end
    end

    assign rline = lines[index];       // Async read
    assign valid = valid_bits[index];
    assign dirty = dirty_bits[index];

    // Controller never refills and write-hits the same cycle
    a_dirty_excl: assert property (@(posedge clk) disable iff (rst)
        !(set_dirty && clear_dirty));

endmodule

`default_nettype wire

// ==== hdl/dcache_access_ctrl.sv ====
`default_nettype none

`include "dcache_consts.svh"

module dcache_access_ctrl (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  dcache_pkg::cpu_req_t         cpu_req,
    input  dcache_pkg::line_t            rline,
    input  wire logic                    valid,
    input  wire logic                    dirty,
    input  dcache_pkg::rd_rsp_t          rd_rsp,
    input  wire logic                    addr_ok_r,
    input  wire logic                    wb_busy,
    input  wire logic                    wb_done,
    output logic [`DC_INDEX_W-1:0]       index,
    output logic                         we,
    output dcache_pkg::line_t            wline,
    output logic                         set_dirty,
    output logic                         clear_dirty,
    output dcache_pkg::rd_req_t          rd_req,
    output dcache_pkg::wb_cmd_t          wb_cmd,
    output logic                         data_ok,
    output logic [`DC_WORD_W-1:0]        rdata
);

    dcache_pkg::ctrl_state_t   state, next_state;
    dcache_pkg::addr_fields_t  af;
    logic [`DC_WORD_W-1:0]     recv_buf [`DC_LINE_WORDS];
    logic [`DC_OFFSET_W-1:0]   recv_cnt;
    logic [`DC_WORD_W-1:0]     cur_word, merged;
    logic [`DC_ADDR_W-1:0]     line_addr, victim_addr;
    logic                      hit, is_write;

    assign af          = dcache_pkg::addr_fields_t'(cpu_req.addr);
    assign index       = af.index;
    assign hit         = valid && (rline.tag == af.tag);
    assign is_write    = |cpu_req.wstrb;
    assign cur_word    = rline.words[af.offset];
    assign line_addr   = {af.tag, af.index, {(`DC_OFFSET_W + 2){1'b0}}};
    assign victim_addr = {rline.tag, af.index, {(`DC_OFFSET_W + 2){1'b0}}};

    // Byte merge for write hits
    always_comb begin
        merged = cur_word;
        for (int b = 0; b < `DC_STRB_W; b++) begin
            if (cpu_req.wstrb[b]) begin
                merged[8*b +: 8] = cpu_req.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || state != dcache_pkg::CACHED_RWAIT) begin
            recv_cnt <= '0;
        end else if (rd_rsp.valid) begin
            recv_cnt <= recv_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == dcache_pkg::CACHED_RWAIT && rd_rsp.valid) begin
            recv_buf[recv_cnt] <= rd_rsp.data;
        end
    end

    always_comb begin
        next_state  = state;
        we          = 1'b0;
        wline       = rline;
        set_dirty   = 1'b0;
        clear_dirty = 1'b0;
        rd_req      = '0;
        wb_cmd      = '0;
        data_ok     = 1'b0;
        rdata       = '0;

        unique case (state)
            dcache_pkg::IDLE: begin
                if (cpu_req.en && cpu_req.uncached && is_write) begin
                    if (!wb_busy) begin
                        wb_cmd.start = 1'b1;
                        wb_cmd.addr  = cpu_req.addr;
                        wb_cmd.word  = cpu_req.wdata;
                        wb_cmd.strb  = cpu_req.wstrb;
                        next_state   = dcache_pkg::UNCACHED_WWAIT;
                    end
                end else if (cpu_req.en && cpu_req.uncached) begin
                    rd_req.valid    = 1'b1;
                    rd_req.addr     = cpu_req.addr;
                    rd_req.uncached = 1'b1;
                    next_state = addr_ok_r ? dcache_pkg::UNCACHED_RETURN
                                           : dcache_pkg::UNCACHED_RSHAKE;
                end else if (cpu_req.en && hit) begin
                    data_ok = 1'b1;
                    if (is_write) begin
                        we                     = 1'b1;
                        set_dirty              = 1'b1;
                        wline.words[af.offset] = merged;
                    end else begin
                        rdata = cur_word;
                    end
                end else if (cpu_req.en && !wb_busy) begin
                    rd_req.valid = 1'b1;
                    rd_req.addr  = line_addr;
                    if (dirty) begin                // Evict victim alongside refill
                        wb_cmd.start = 1'b1;
                        wb_cmd.line  = 1'b1;
                        wb_cmd.addr  = victim_addr;
                    end
                    next_state = addr_ok_r ? dcache_pkg::CACHED_RWAIT
                                           : dcache_pkg::CACHED_RSHAKE;
                end
            end
            dcache_pkg::CACHED_RSHAKE: begin
                rd_req.valid = 1'b1;
                rd_req.addr  = line_addr;
                if (addr_ok_r) begin
                    next_state = dcache_pkg::CACHED_RWAIT;
                end
            end
            dcache_pkg::CACHED_RWAIT: begin
                if (rd_rsp.valid && rd_rsp.last) begin
                    next_state = wb_busy ? dcache_pkg::CACHED_WWAIT
                                         : dcache_pkg::CACHED_REFILL;
                end
            end
            dcache_pkg::CACHED_WWAIT: begin
                if (!wb_busy) begin
                    next_state = dcache_pkg::CACHED_REFILL;
                end
            end
            dcache_pkg::CACHED_REFILL: begin
                we          = 1'b1;
                clear_dirty = 1'b1;
                wline.tag   = af.tag;
                for (int w = 0; w < `DC_LINE_WORDS; w++) begin
                    wline.words[w] = recv_buf[w];
                end
                data_ok    = !is_write;   // Writes replay as a hit
                rdata      = recv_buf[af.offset];
                next_state = dcache_pkg::IDLE;
            end
            dcache_pkg::UNCACHED_RSHAKE: begin
                rd_req.valid    = 1'b1;
                rd_req.addr     = cpu_req.addr;
                rd_req.uncached = 1'b1;
                if (addr_ok_r) begin
                    next_state = dcache_pkg::UNCACHED_RETURN;
                end
            end
            dcache_pkg::UNCACHED_RETURN: begin
                data_ok = rd_rsp.valid;
                rdata   = rd_rsp.data;
                if (rd_rsp.valid && rd_rsp.last) begin
                    next_state = dcache_pkg::IDLE;
                end
            end
            dcache_pkg::UNCACHED_WWAIT: begin
                data_ok = wb_done;
                if (wb_done) begin
                    next_state = dcache_pkg::IDLE;
                end
            end
            default: next_state = dcache_pkg::IDLE;
        endcase
    end

    // Read data only comes back for a request this FSM issued
    a_rsp_state: assert property (@(posedge clk) disable iff (rst)
        rd_rsp.valid |-> (state == dcache_pkg::CACHED_RWAIT ||
                          state == dcache_pkg::UNCACHED_RETURN));

endmodule

`default_nettype wire

// ==== hdl/dcache_write_engine.sv ====
`default_nettype none

`include "dcache_consts.svh"

module dcache_write_engine (
    input  wire logic             clk,
    input  wire logic             rst,
    input  dcache_pkg::wb_cmd_t   wb_cmd,
    input  dcache_pkg::line_t     rline,
    input  dcache_pkg::wr_rsp_t   wr_rsp,
    output dcache_pkg::wr_req_t   wr_req,
    output dcache_pkg::wr_beat_t  wr_beat,
    output logic                  wb_busy,
    output logic                  wb_done
);

    dcache_pkg::wr_state_t    state, next_state;
    dcache_pkg::wb_cmd_t      cmd;
    logic [`DC_OFFSET_W-1:0]  beat_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::WIDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (state == dcache_pkg::WIDLE && wb_cmd.start) begin
            cmd <= wb_cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || state != dcache_pkg::WWRITE) begin
            beat_cnt <= '0;
        end else if (wr_rsp.wready) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign wb_busy = (state != dcache_pkg::WIDLE);
    assign wb_done = (state == dcache_pkg::WRESULT) && wr_rsp.bvalid;

    always_comb begin
        next_state = state;
        wr_req     = '0;
        wr_beat    = '0;

        unique case (state)
            dcache_pkg::WIDLE: begin
                if (wb_cmd.start) begin         // Address goes out right away
                    wr_req.valid    = 1'b1;
                    wr_req.addr     = wb_cmd.addr;
                    wr_req.uncached = !wb_cmd.line;
                    wr_req.strb     = wb_cmd.line ? {`DC_STRB_W{1'b1}} : wb_cmd.strb;
                    next_state = wr_rsp.addr_ok ? dcache_pkg::WWRITE : dcache_pkg::WSHAKE;
                end
            end
            dcache_pkg::WSHAKE: begin
                wr_req.valid    = 1'b1;
                wr_req.addr     = cmd.addr;
                wr_req.uncached = !cmd.line;
                wr_req.strb     = cmd.line ? {`DC_STRB_W{1'b1}} : cmd.strb;
                if (wr_rsp.addr_ok) begin
                    next_state = dcache_pkg::WWRITE;
                end
            end
            dcache_pkg::WWRITE: begin
                wr_beat.valid = 1'b1;
                wr_beat.data  = cmd.line ? rline.words[beat_cnt] : cmd.word;
                wr_beat.strb  = cmd.line ? {`DC_STRB_W{1'b1}} : cmd.strb;
                wr_beat.last  = !cmd.line || (&beat_cnt);
                if (wr_rsp.wready && wr_beat.last) begin
                    next_state = dcache_pkg::WRESULT;
                end
            end
            dcache_pkg::WRESULT: begin
                if (wr_rsp.bvalid) begin
                    next_state = dcache_pkg::WIDLE;
                end
            end
            default: next_state = dcache_pkg::WIDLE;
        endcase
    end

    // Controller only starts a write once the engine is free
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        wb_cmd.start |-> !wb_busy);

endmodule

`default_nettype wire

// ==== hdl/dcache_top.sv ====
`default_nettype none

`include "dcache_consts.svh"

module dcache_top (
    input  wire logic               clk,
    input  wire logic               rst,
    input  dcache_pkg::cpu_req_t    cpu_req,
    output logic                    data_ok,
    output logic [`DC_WORD_W-1:0]   rdata,
    output dcache_pkg::rd_req_t     rd_req,
    input  dcache_pkg::rd_rsp_t     rd_rsp,
    input  wire logic               addr_ok_r,
    output dcache_pkg::wr_req_t     wr_req,
    output dcache_pkg::wr_beat_t    wr_beat,
    input  dcache_pkg::wr_rsp_t     wr_rsp
);

    logic [`DC_INDEX_W-1:0]  index;
    logic                    we, valid, dirty;
    logic                    set_dirty, clear_dirty;
    dcache_pkg::line_t       wline, rline;
    dcache_pkg::wb_cmd_t     wb_cmd;
    logic                    wb_busy, wb_done;

    dcache_line_store u_store (
        .clk         (clk),
        .rst         (rst),
        .index       (index),
        .we          (we),
        .wline       (wline),
        .set_dirty   (set_dirty),
        .clear_dirty (clear_dirty),
        .rline       (rline),
        .valid       (valid),
        .dirty       (dirty)
    );

    dcache_access_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .rline       (rline),
        .valid       (valid),
        .dirty       (dirty),
        .rd_rsp      (rd_rsp),
        .addr_ok_r   (addr_ok_r),
        .wb_busy     (wb_busy),
        .wb_done     (wb_done),
        .index       (index),
        .we          (we),
        .wline       (wline),
        .set_dirty   (set_dirty),
        .clear_dirty (clear_dirty),
        .rd_req      (rd_req),
        .wb_cmd      (wb_cmd),
        .data_ok     (data_ok),
        .rdata       (rdata)
    );

    // Writeback words come straight from the indexed line
    dcache_write_engine u_wr (
        .clk         (clk),
        .rst         (rst),
        .wb_cmd      (wb_cmd),
        .rline       (rline),
        .wr_rsp      (wr_rsp),
        .wr_req      (wr_req),
        .wr_beat     (wr_beat),
        .wb_busy     (wb_busy),
        .wb_done     (wb_done)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clkgen.sv ====
`default_nettype none

module tb_clkgen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;    // Period 100

endmodule

`default_nettype wire

// ==== testbench/tb_mem_model.sv ====
`default_nettype none

module tb_mem_model (
    input  wire logic              clk,
    input  wire logic              rst,
    input  dcache_pkg::rd_req_t    rd_req,
    output dcache_pkg::rd_rsp_t    rd_rsp,
    output logic                   addr_ok_r,
    input  dcache_pkg::wr_req_t    wr_req,
    input  dcache_pkg::wr_beat_t   wr_beat,
    output dcache_pkg::wr_rsp_t    wr_rsp,
    output logic                   proto_err
);

    logic [31:0] mem [bit [31:0]];
    logic        rd_busy, wr_busy, wr_resp_wait;
    logic [3:0]  wr_strb;
    logic [31:0] rd_addr, wr_addr, cur;
    int          rd_left, rd_beat, wr_cnt, wr_len;

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] a);
        return mem.exists(a) ? mem[a] : fill_word(a);
    endfunction

    task automatic flag(input string what);
        $display("Memory model error at time %0t: %s", $time, what);
        proto_err = 1'b1;
    endtask

    task automatic sample_read();
        if (rd_rsp.valid) begin
            rd_beat++;
            rd_left--;
            if (rd_rsp.last) begin
                rd_busy = 1'b0;
            end
        end
        if (rd_req.valid && addr_ok_r) begin
            if (rd_req.uncached != rd_req.addr[31]) begin
                flag("read uncached flag does not match the address region");
            end
            if (!rd_req.uncached && rd_req.addr[5:0] != 6'd0) begin
                flag("burst read address is not line aligned");
            end
            rd_busy = 1'b1;
            rd_addr = {rd_req.addr[31:2], 2'b00};
            rd_left = rd_req.uncached ? 1 : 16;
            rd_beat = 0;
        end
    endtask

    task automatic sample_write();
        if (wr_rsp.bvalid) begin
            wr_resp_wait = 1'b0;
            wr_busy      = 1'b0;
        end
        if (wr_beat.valid && wr_rsp.wready) begin
            if (wr_beat.strb != wr_strb) begin
                flag("write beat byte enables differ from the address phase");
            end
            cur = read_word(wr_addr + 32'(4 * wr_cnt));
            for (int b = 0; b < 4; b++) begin
                if (wr_beat.strb[b]) begin
                    cur[8*b +: 8] = wr_beat.data[8*b +: 8];
                end
            end
            mem[wr_addr + 32'(4 * wr_cnt)] = cur;
            wr_cnt++;
            if (wr_beat.last) begin
                if (wr_cnt != wr_len) begin
                    flag("write burst does not have the expected number of beats");
                end
                wr_resp_wait = 1'b1;
            end else if (wr_cnt >= wr_len) begin
                flag("write burst runs past its expected last beat");
            end
        end
        if (wr_req.valid && wr_rsp.addr_ok) begin
            if (wr_req.uncached != wr_req.addr[31]) begin
                flag("single write to the cached region or burst to the uncached region");
            end
            if (!wr_req.uncached && wr_req.addr[5:0] != 6'd0) begin
                flag("writeback address is not line aligned");
            end
            if (!wr_req.uncached && wr_req.strb != 4'hf) begin
                flag("writeback address phase does not enable all bytes");
            end
            wr_busy      = 1'b1;
            wr_resp_wait = 1'b0;
            wr_addr      = {wr_req.addr[31:2], 2'b00};
            wr_strb      = wr_req.strb;
            wr_len       = wr_req.uncached ? 1 : 16;
            wr_cnt       = 0;
        end
    endtask

    initial begin
        rd_rsp       = '0;
        wr_rsp       = '0;
        addr_ok_r    = 1'b0;
        proto_err    = 1'b0;
        rd_busy      = 1'b0;
        wr_busy      = 1'b0;
        wr_resp_wait = 1'b0;
        wr_strb      = 4'd0;
        forever begin
            @(posedge clk);
            if (rst) begin
                rd_busy      = 1'b0;
                wr_busy      = 1'b0;
                wr_resp_wait = 1'b0;
            end else begin
                sample_read();
                sample_write();
            end
            #10;
            // Random accept and data delays
            addr_ok_r     = !rst && !rd_busy && ($urandom_range(0, 2) != 0);
            rd_rsp.valid  = rd_busy && ($urandom_range(0, 3) != 0);
            rd_rsp.data   = rd_busy ? read_word(rd_addr + 32'(4 * rd_beat)) : 32'd0;
            rd_rsp.last   = rd_busy && (rd_left == 1);
            wr_rsp.addr_ok = !rst && !wr_busy && ($urandom_range(0, 2) != 0);
            wr_rsp.wready  = wr_busy && !wr_resp_wait && ($urandom_range(0, 3) != 0);
            wr_rsp.bvalid  = wr_resp_wait && ($urandom_range(0, 2) != 0);
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_dcache.sv ====
`default_nettype none

module tb_dcache;

    localparam int N_OPS    = 2000;
    localparam int WATCHDOG = N_OPS * 200 * 100;

    logic                  clk, rst, data_ok, addr_ok_r, proto_err;
    logic [31:0]           rdata;
    dcache_pkg::cpu_req_t  cpu_req;
    dcache_pkg::rd_req_t   rd_req;
    dcache_pkg::rd_rsp_t   rd_rsp;
    dcache_pkg::wr_req_t   wr_req;
    dcache_pkg::wr_beat_t  wr_beat;
    dcache_pkg::wr_rsp_t   wr_rsp;

    logic [31:0]  model_mem [bit [31:0]];
    logic [18:0]  tag_pool [6] = '{19'h1, 19'h2, 19'h3, 19'h15, 19'h2a, 19'h7f};
    logic [6:0]   idx_pool [4] = '{7'd0, 7'd5, 7'd64, 7'd127};

    tb_clkgen u_clk (.clk(clk));

    tb_mem_model u_mem (
        .clk       (clk),
        .rst       (rst),
        .rd_req    (rd_req),
        .rd_rsp    (rd_rsp),
        .addr_ok_r (addr_ok_r),
        .wr_req    (wr_req),
        .wr_beat   (wr_beat),
        .wr_rsp    (wr_rsp),
        .proto_err (proto_err)
    );

    dcache_top DUT (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_rsp    (rd_rsp),
        .addr_ok_r (addr_ok_r),
        .wr_req    (wr_req),
        .wr_beat   (wr_beat),
        .wr_rsp    (wr_rsp)
    );

    // Same power-on contents as the memory model
    function automatic logic [31:0] init_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] a);
        return model_mem.exists(a) ? model_mem[a] : init_word(a);
    endfunction

    task automatic model_write(input logic [31:0] a, input logic [3:0] strb,
                               input logic [31:0] d);
        logic [31:0] w;
        w = model_read(a);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[8*b +: 8] = d[8*b +: 8];
            end
        end
        model_mem[a] = w;
    endtask

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp,
                             input string msg);
        if (got !== exp) begin
            $display("ERR @%0t: %s: got %h, expected %h", $time, msg, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Holds the request until data_ok and counts the wait cycles in lat
    task automatic access(input logic [31:0] addr, input logic [3:0] strb,
                          input logic [31:0] wdata, input logic unc,
                          output logic [31:0] data, output int lat);
        cpu_req.en       = 1'b1;
        cpu_req.wstrb    = strb;
        cpu_req.addr     = addr;
        cpu_req.wdata    = wdata;
        cpu_req.uncached = unc;
        lat = 0;
        @(posedge clk);
        while (!data_ok) begin
            lat++;
            @(posedge clk);
        end
        data = rdata;
        if (unc && strb != 4'd0) begin
            check_val({31'd0, wr_rsp.bvalid}, 32'd1, "uncached write done outside bvalid");
        end
        #10;
        cpu_req.en = 1'b0;
    endtask

    function automatic logic [31:0] pick_cached();
        return {tag_pool[$urandom_range(0, 5)], idx_pool[$urandom_range(0, 3)],
                4'($urandom_range(0, 15)), 2'b00};
    endfunction

    always @(posedge proto_err) begin
        $display("The memory model saw a bus protocol violation");
        $display("TEST FAIL");
        $fatal(1, "bus protocol violation");
    end

    initial begin
        #(WATCHDOG);
        $display("Watchdog expired before the test sequence finished");
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] addr, wdata, data;
        logic [3:0]  strb;
        int          lat;

        void'($urandom(15));
        rst     = 1'b1;
        cpu_req = '0;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;
        @(posedge clk);
        check_val({31'd0, data_ok}, 32'd0, "data_ok after reset");
        check_val({31'd0, rd_req.valid}, 32'd0, "read valid after reset");
        check_val({31'd0, wr_req.valid}, 32'd0, "write valid after reset");
        check_val({31'd0, wr_beat.valid}, 32'd0, "beat valid after reset");
        #10;

        for (int i = 0; i < N_OPS; i++) begin
            if ($urandom_range(0, 9) < 7) begin
                addr = pick_cached();
                if ($urandom_range(0, 1) == 1) begin
                    strb  = 4'($urandom_range(1, 15));
                    wdata = $urandom;
                    access(addr, strb, wdata, 1'b0, data, lat);
                    model_write(addr, strb, wdata);
                end else begin
                    access(addr, 4'd0, 32'd0, 1'b0, data, lat);
                    check_val(data, model_read(addr), "cached read");
                end
                // Line is resident now so a re-read must hit
                if ($urandom_range(0, 2) == 0) begin
                    access(addr, 4'd0, 32'd0, 1'b0, data, lat);
                    check_val(data, model_read(addr), "cached re-read");
                    check_val(32'(lat), 32'd0, "hit latency");
                end
            end else begin
                addr = 32'h8000_0000 | 32'($urandom_range(0, 63) << 2);
                if ($urandom_range(0, 1) == 1) begin
                    strb  = 4'($urandom_range(1, 15));
                    wdata = $urandom;
                    access(addr, strb, wdata, 1'b1, data, lat);
                    model_write(addr, strb, wdata);
                end else begin
                    access(addr, 4'd0, 32'd0, 1'b1, data, lat);
                    check_val(data, model_read(addr), "uncached read");
                end
            end
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_line_store.sv
hdl/dcache_access_ctrl.sv
hdl/dcache_write_engine.sv
hdl/dcache_top.sv
testbench/tb_clkgen.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then decide from the log
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_dcache -o tb_dcache_sim \
    && ./obj_dir/tb_dcache_sim > sim.log 2>&1 \
    || echo "Build or simulation returned an error: TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0
